// File: rtl/fx_add.sv
// Q8.8 adder
// saturating sum carried through LATENCY registers with its valid

`timescale 1ns/100ps
`include "ssm_config.svh"

module fx_add
    import ssm_data_pkg::*;
#(
    parameter int LATENCY = `SSM_A_LAT
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  valid_in,
    input  elem_t a,
    input  elem_t b,
    output elem_t result,
    output logic  valid_out
);

    localparam int DW = `SSM_DW;

    logic signed [DW:0] sum;     // one guard bit
    elem_t              sat;
    elem_t              res_q [LATENCY];
    logic [LATENCY-1:0] vld_q;

    always_comb begin
        sum = a + b;
        if (sum[DW] != sum[DW-1]) begin
            sat = sum[DW] ? {1'b1, {(DW-1){1'b0}}} : {1'b0, {(DW-1){1'b1}}};
        end else begin
            sat = sum[DW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        res_q[0] <= sat;
        for (int i = 1; i < LATENCY; i++) begin
            res_q[i] <= res_q[i-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= valid_in;
            for (int i = 1; i < LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    assign result    = res_q[LATENCY-1];
    assign valid_out = vld_q[LATENCY-1];

endmodule

// File: rtl/fx_mult.sv
// Q8.8 multiplier
// product rescaled and saturated in the first stage, then LATENCY registers

`timescale 1ns/100ps
`include "ssm_config.svh"

module fx_mult
    import ssm_data_pkg::*;
#(
    parameter int LATENCY = `SSM_M_LAT
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  valid_in,
    input  elem_t a,
    input  elem_t b,
    output elem_t result,
    output logic  valid_out
);

    localparam int DW = `SSM_DW;
    localparam logic signed [2*DW-1:0] SAT_HI = (2 ** (DW - 1)) - 1;
    localparam logic signed [2*DW-1:0] SAT_LO = -(2 ** (DW - 1));

    logic signed [2*DW-1:0] prod;
    logic signed [2*DW-1:0] scaled;
    elem_t                  sat;
    elem_t                  res_q [LATENCY];
    logic [LATENCY-1:0]     vld_q;

    always_comb begin
        prod   = a * b;              // full width signed
        scaled = prod >>> `SSM_FRAC;
        if (scaled > SAT_HI) begin
            sat = elem_t'(SAT_HI);
        end else if (scaled < SAT_LO) begin
            sat = elem_t'(SAT_LO);
        end else begin
            sat = elem_t'(scaled);
        end
    end

    always_ff @(posedge clk) begin
        res_q[0] <= sat;
        for (int i = 1; i < LATENCY; i++) begin
            res_q[i] <= res_q[i-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= valid_in;
            for (int i = 1; i < LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    assign result    = res_q[LATENCY-1];
    assign valid_out = vld_q[LATENCY-1];

endmodule

// File: rtl/hc_lane.sv
// one hc lane
// ((dt * x) * bmat + dah) * c with operands and tag delayed to meet each unit

`timescale 1ns/100ps
`include "ssm_config.svh"

module hc_lane
    import ssm_data_pkg::*;
    import ssm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    input  logic      dah_done,
    input  elem_t     dt,
    input  elem_t     x,
    input  lane_ops_t ops,
    input  lane_tag_t tag,
    output logic      res_valid,
    output elem_t     res,
    output lane_tag_t res_tag
);

    localparam int M_LAT = `SSM_M_LAT;
    localparam int A_LAT = `SSM_A_LAT;
    localparam int LAT   = 3 * M_LAT + A_LAT;

    elem_t     dx, dxb, sum;
    elem_t     bmat_d, dah_d, c_d;
    logic      dx_valid, dxb_valid, sum_valid, add_valid, prod_valid;

    // ========================================================================
    // operand alignment
    // ========================================================================
    tag_delay #(.item_t(elem_t), .DEPTH(M_LAT)) u_bmat_dly (
        .clk(clk), .rst(rst), .d(ops.bmat), .q(bmat_d)
    );

    tag_delay #(.item_t(elem_t), .DEPTH(2 * M_LAT)) u_dah_dly (
        .clk(clk), .rst(rst), .d(ops.dah), .q(dah_d)
    );

    tag_delay #(.item_t(elem_t), .DEPTH(2 * M_LAT + A_LAT)) u_c_dly (
        .clk(clk), .rst(rst), .d(ops.c), .q(c_d)
    );

    tag_delay #(.item_t(lane_tag_t), .DEPTH(LAT)) u_tag_dly (
        .clk(clk), .rst(rst), .d(tag), .q(res_tag)
    );

    // ========================================================================
    // arithmetic chain
    // ========================================================================
    fx_mult #(.LATENCY(M_LAT)) u_mul1 (
        .clk(clk), .rst(rst), .valid_in(valid),
        .a(dt), .b(x), .result(dx), .valid_out(dx_valid)
    );

    fx_mult #(.LATENCY(M_LAT)) u_mul2 (
        .clk(clk), .rst(rst), .valid_in(dx_valid),
        .a(dx), .b(bmat_d), .result(dxb), .valid_out(dxb_valid)
    );

    assign add_valid = dxb_valid & dah_done;  // dah not ready, drop it

    fx_add #(.LATENCY(A_LAT)) u_add (
        .clk(clk), .rst(rst), .valid_in(add_valid),
        .a(dxb), .b(dah_d), .result(sum), .valid_out(sum_valid)
    );

    fx_mult #(.LATENCY(M_LAT)) u_mul3 (
        .clk(clk), .rst(rst), .valid_in(sum_valid),
        .a(sum), .b(c_d), .result(res), .valid_out(prod_valid)
    );

    // padded lanes never reach the store
    assign res_valid = prod_valid & res_tag.live;

endmodule

// File: rtl/hc_pipeline.sv
// hc pipeline top
// walks b, h, p, n in groups of PAR lanes, collects results by tag into hc
// and pulses done once the last group has drained

`timescale 1ns/100ps
`include "ssm_config.svh"

module hc_pipeline
    import ssm_data_pkg::*;
    import ssm_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    dah_done,
    input  dt_vec_t dt,
    input  x_vec_t  x,
    input  bn_vec_t bmat,
    input  bn_vec_t c,
    input  hc_vec_t dah,
    output hc_vec_t hc,
    output logic    done
);

    localparam int B       = `SSM_B;
    localparam int H       = `SSM_H;
    localparam int P       = `SSM_P;
    localparam int N       = `SSM_N;
    localparam int PAR     = `SSM_PAR;
    localparam int IDX_W   = `SSM_IDX_W;
    localparam int LAT     = 3 * `SSM_M_LAT + `SSM_A_LAT;
    localparam int FLUSH_W = $clog2(LAT + 1);

    seq_state_t         state;
    idx_t               cur;        // group base index
    logic [FLUSH_W-1:0] flush_cnt;

    elem_t     dt_sel, dt_q;
    lane_tag_t tag_sel [PAR];
    lane_tag_t tag_q   [PAR];
    lane_ops_t ops_sel [PAR];
    lane_ops_t ops_q   [PAR];
    logic      issue_valid;

    logic [PAR-1:0] lane_res_valid;
    elem_t          lane_res     [PAR];
    lane_tag_t      lane_res_tag [PAR];

    function automatic int flat_idx(idx_t t);
        return ((int'(t.b) * H + int'(t.h)) * P + int'(t.p)) * N + int'(t.n);
    endfunction

    // ========================================================================
    // sequencer
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            cur       <= '0;
            flush_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        cur       <= '0;
                        flush_cnt <= '0;
                        state     <= CALC;
                    end
                end
                CALC: begin
                    // n fastest, then p, h, b
                    if (int'(cur.n) + PAR >= N) begin
                        cur.n <= '0;
                        if (cur.p == IDX_W'(P - 1)) begin
                            cur.p <= '0;
                            if (cur.h == IDX_W'(H - 1)) begin
                                cur.h <= '0;
                                if (cur.b == IDX_W'(B - 1)) begin
                                    state <= FLUSH;   // last group out
                                end else begin
                                    cur.b <= cur.b + 1'b1;
                                end
                            end else begin
                                cur.h <= cur.h + 1'b1;
                            end
                        end else begin
                            cur.p <= cur.p + 1'b1;
                        end
                    end else begin
                        cur.n <= cur.n + IDX_W'(PAR);
                    end
                end
                FLUSH: begin
                    if (flush_cnt == FLUSH_W'(LAT - 1)) begin
                        state <= FIN;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end
                FIN: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ========================================================================
    // operand select and issue
    // ========================================================================
    always_comb begin
        int bh;
        int bhp;
        int nn;
        bh     = int'(cur.b) * H + int'(cur.h);
        bhp    = bh * P + int'(cur.p);
        dt_sel = dt[bh];
        for (int i = 0; i < PAR; i++) begin
            nn                = int'(cur.n) + i;
            tag_sel[i].idx.b  = cur.b;
            tag_sel[i].idx.h  = cur.h;
            tag_sel[i].idx.p  = cur.p;
            tag_sel[i].idx.n  = IDX_W'(nn);
            tag_sel[i].live   = (nn < N);
            if (nn >= N) begin
                nn = 0;  // padded lane, any in-range slot
            end
            ops_sel[i].bmat = bmat[int'(cur.b) * N + nn];
            ops_sel[i].c    = c[int'(cur.b) * N + nn];
            ops_sel[i].dah  = dah[bhp * N + nn];
            ops_sel[i].x    = x[bhp];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= (state == CALC);
        end
    end

    always_ff @(posedge clk) begin
        dt_q  <= dt_sel;
        tag_q <= tag_sel;
        ops_q <= ops_sel;
    end

    // ========================================================================
    // lanes and result store
    // ========================================================================
    for (genvar g = 0; g < PAR; g++) begin : g_lane
        hc_lane u_lane (
            .clk(clk),
            .rst(rst),
            .valid(issue_valid),
            .dah_done(dah_done),
            .dt(dt_q),
            .x(ops_q[g].x),
            .ops(ops_q[g]),
            .tag(tag_q[g]),
            .res_valid(lane_res_valid[g]),
            .res(lane_res[g]),
            .res_tag(lane_res_tag[g])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hc <= '0;
        end else begin
            for (int i = 0; i < PAR; i++) begin
                if (lane_res_valid[i]) begin
                    hc[flat_idx(lane_res_tag[i].idx)] <= lane_res[i];
                end
            end
        end
    end

endmodule

// File: rtl/ssm_config.svh
// SSM state update configuration
// dimensions, element format, unit latencies and lane count

`ifndef SSM_CONFIG_SVH
`define SSM_CONFIG_SVH

// ==========================================================================
// problem dimensions
// ==========================================================================
`define SSM_B      1  // batches
`define SSM_H      2  // heads
`define SSM_P      2  // channels per head
`define SSM_N      4  // state size

// ==========================================================================
// numeric format and datapath
// ==========================================================================
`define SSM_DW     16 // Q8.8 element
`define SSM_FRAC   8
`define SSM_M_LAT  2  // multiplier cycles
`define SSM_A_LAT  1  // adder cycles
`define SSM_PAR    2  // lanes
`define SSM_IDX_W  4

`endif

// File: rtl/ssm_ctrl_pkg.sv
// SSM control types
// element index, lane tag and sequencer states

`include "ssm_config.svh"

package ssm_ctrl_pkg;

    typedef struct packed {
        logic [`SSM_IDX_W-1:0] b;
        logic [`SSM_IDX_W-1:0] h;
        logic [`SSM_IDX_W-1:0] p;
        logic [`SSM_IDX_W-1:0] n;
    } idx_t;

    // live is low for padded lanes past the end of n
    typedef struct packed {
        idx_t idx;
        logic live;
    } lane_tag_t;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        FLUSH,
        FIN
    } seq_state_t;

endpackage

// File: rtl/ssm_data_pkg.sv
// SSM numeric types
// Q8.8 element and the flattened operand vectors, row-major b, h, p, n

`include "ssm_config.svh"

package ssm_data_pkg;

    // signed fixed point, 8 fraction bits
    typedef logic signed [`SSM_DW-1:0] elem_t;

    // element g sits at position g, lowest bits first
    typedef elem_t [`SSM_B*`SSM_H-1:0] dt_vec_t;
    typedef elem_t [`SSM_B*`SSM_N-1:0] bn_vec_t;              // bmat and c
    typedef elem_t [`SSM_B*`SSM_H*`SSM_P-1:0] x_vec_t;
    typedef elem_t [`SSM_B*`SSM_H*`SSM_P*`SSM_N-1:0] hc_vec_t; // dah and hc

    // operands captured per lane at issue
    typedef struct packed {
        elem_t bmat;
        elem_t dah;
        elem_t c;
        elem_t x;
    } lane_ops_t;

endpackage

// File: rtl/tag_delay.sv
// fixed-depth delay line
// shifts any packed item by DEPTH cycles, cleared on reset

`timescale 1ns/100ps

module tag_delay #(
    parameter type item_t = logic [15:0],
    parameter int  DEPTH  = 1
) (
    input  logic  clk,
    input  logic  rst,
    input  item_t d,
    output item_t q
);

    item_t pipe [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign q = pipe[DEPTH-1];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the hc pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module hc_pipeline_tb -Mdir obj_dir

out=$(./obj_dir/Vhc_pipeline_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -q "^test passed$"

// File: sources.f
+incdir+rtl
rtl/ssm_data_pkg.sv
rtl/ssm_ctrl_pkg.sv
rtl/fx_mult.sv
rtl/fx_add.sv
rtl/tag_delay.sv
rtl/hc_lane.sv
rtl/hc_pipeline.sv
testbench/hc_pipeline_checker.sv
testbench/hc_pipeline_tb.sv

// File: testbench/hc_pipeline_checker.sv
// hc pipeline checker
// done pulse shape and lane result tags, bound into the top level

`timescale 1ns/100ps
`include "ssm_config.svh"

module hc_pipeline_checker
    import ssm_ctrl_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                done,
    input logic [`SSM_PAR-1:0] lane_res_valid,
    input lane_tag_t           lane_res_tag [`SSM_PAR]
);

    int fail_count = 0;  // failed assertions so far

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    done_low_in_reset: assert property (@(posedge clk) rst |-> !done)
        else begin
            fail_count++;
            $error("done high while reset is asserted");
        end

    for (genvar i = 0; i < `SSM_PAR; i++) begin : g_tag
        // a delivered result must name a real element
        tag_live: assert property (@(posedge clk) disable iff (rst)
            lane_res_valid[i] |-> (int'(lane_res_tag[i].idx.b) < `SSM_B
                && int'(lane_res_tag[i].idx.h) < `SSM_H
                && int'(lane_res_tag[i].idx.p) < `SSM_P
                && int'(lane_res_tag[i].idx.n) < `SSM_N))
            else begin
                fail_count++;
                $error("lane %0d result tag points past the hc store", i);
            end
    end

endmodule

// File: testbench/hc_pipeline_tb.sv
// hc pipeline testbench
// table-driven runs checked against a Q8.8 model of the hc rule

`timescale 1ns/100ps
`include "ssm_config.svh"

module hc_pipeline_tb
    import ssm_data_pkg::*;
();

    localparam int B          = `SSM_B;
    localparam int H          = `SSM_H;
    localparam int P          = `SSM_P;
    localparam int N          = `SSM_N;
    localparam int PAR        = `SSM_PAR;
    localparam int LAT        = 3 * `SSM_M_LAT + `SSM_A_LAT;
    localparam int G          = B * H * P * ((N + PAR - 1) / PAR);
    localparam int NUM_HC     = B * H * P * N;
    localparam int NUM_ROWS   = 7;
    localparam int WATCHDOG   = (NUM_ROWS + 1) * (G + LAT + 10) * 100;
    localparam int MODE_FIXED = 0;
    localparam int MODE_RAND  = 1;
    localparam int MODE_SAT   = 2;

    typedef struct packed {
        logic [1:0] mode;
        logic       dah_lvl;
        logic       held;       // hc keeps the previous run
        logic       mid_start;  // extra start pulse during calc
    } row_t;

    logic    clk;
    logic    rst;
    logic    start;
    logic    dah_done;
    dt_vec_t dt;
    x_vec_t  x;
    bn_vec_t bmat;
    bn_vec_t c;
    hc_vec_t dah;
    hc_vec_t hc;
    logic    done;

    hc_vec_t exp_hc;
    row_t    rows [NUM_ROWS];
    int      done_count = 0;

    hc_pipeline dut (
        .clk(clk), .rst(rst), .start(start), .dah_done(dah_done),
        .dt(dt), .x(x), .bmat(bmat), .c(c), .dah(dah),
        .hc(hc), .done(done)
    );

    bind hc_pipeline hc_pipeline_checker u_checker (
        .clk(clk), .rst(rst), .done(done),
        .lane_res_valid(lane_res_valid), .lane_res_tag(lane_res_tag)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (done === 1'b1) done_count <= done_count + 1;
    end

    always @(negedge clk) begin
        check_value("checker fail_count", dut.u_checker.fail_count, 0);
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: the DUT did not finish all runs in time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================================================
    // reference arithmetic
    // ========================================================================
    function automatic elem_t clamp(int v);
        if (v > 32767) return elem_t'(32767);
        if (v < -32768) return elem_t'(-32768);
        return elem_t'(v);
    endfunction

    function automatic elem_t q_mul(elem_t a, elem_t b);
        int p;
        p = int'(a) * int'(b);
        return clamp(p >>> `SSM_FRAC);
    endfunction

    function automatic elem_t q_add(elem_t a, elem_t b);
        return clamp(int'(a) + int'(b));
    endfunction

    function automatic elem_t pick(int mode, elem_t fixed_val);
        case (mode)
            MODE_FIXED: return fixed_val;
            MODE_RAND:  return elem_t'(int'($urandom % 1024) - 512);  // +-2.0
            default:    return elem_t'($urandom);                     // mostly large
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_done();
        do @(negedge clk); while (done !== 1'b1);
    endtask

    // ========================================================================
    // one table row
    // ========================================================================
    task automatic run_row(input int r);
        dt_vec_t dt_n;
        x_vec_t  x_n;
        bn_vec_t b_n;
        bn_vec_t c_n;
        hc_vec_t dah_n;
        int      bh;
        int      bhp;
        int      g;
        for (int i = 0; i < B * H; i++) dt_n[i] = pick(rows[r].mode, 16'sh0100);
        for (int i = 0; i < B * H * P; i++) x_n[i] = pick(rows[r].mode, 16'sh0200);
        for (int i = 0; i < B * N; i++) begin
            b_n[i] = pick(rows[r].mode, 16'sh0080);
            c_n[i] = pick(rows[r].mode, 16'sh0200);
        end
        for (int i = 0; i < NUM_HC; i++) dah_n[i] = pick(rows[r].mode, 16'sh0040);
        if (!rows[r].held) begin
            for (int bi = 0; bi < B; bi++) begin
                for (int hi = 0; hi < H; hi++) begin
                    for (int pi = 0; pi < P; pi++) begin
                        for (int ni = 0; ni < N; ni++) begin
                            bh  = bi * H + hi;
                            bhp = bh * P + pi;
                            g   = bhp * N + ni;
                            exp_hc[g] = q_mul(q_add(q_mul(q_mul(dt_n[bh], x_n[bhp]),
                                b_n[bi * N + ni]), dah_n[g]), c_n[bi * N + ni]);
                            if (rows[r].mode == MODE_FIXED) exp_hc[g] = 16'sh0280; // 2.5
                        end
                    end
                end
            end
        end
        @(posedge clk);
        dt       <= dt_n;
        x        <= x_n;
        bmat     <= b_n;
        c        <= c_n;
        dah      <= dah_n;
        dah_done <= rows[r].dah_lvl;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (rows[r].mid_start) begin
            repeat (3) @(posedge clk);
            start <= 1'b1;  // should be ignored
            @(posedge clk);
            start <= 1'b0;
        end
        wait_done();
        for (int i = 0; i < NUM_HC; i++) begin
            check_value($sformatf("hc[%0d]", i), hc[i], exp_hc[i]);
        end
        @(posedge clk);
        check_value("done_count", done_count, r + 1);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        void'($urandom(32'h6cc4));
        rst      = 1'b0;
        start    = 1'b0;
        dah_done = 1'b0;
        dt       = '0;
        x        = '0;
        bmat     = '0;
        c        = '0;
        dah      = '0;
        exp_hc   = '0;
        //          mode        dah  held mid
        rows[0] = '{2'(MODE_FIXED), 1'b1, 1'b0, 1'b0};
        rows[1] = '{2'(MODE_RAND),  1'b1, 1'b0, 1'b1};
        rows[2] = '{2'(MODE_SAT),   1'b1, 1'b0, 1'b0};
        rows[3] = '{2'(MODE_RAND),  1'b0, 1'b1, 1'b0};
        rows[4] = '{2'(MODE_RAND),  1'b1, 1'b0, 1'b0};
        rows[5] = '{2'(MODE_FIXED), 1'b0, 1'b1, 1'b0};
        rows[6] = '{2'(MODE_RAND),  1'b1, 1'b0, 1'b0};

        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("done", done, 0);
        for (int i = 0; i < NUM_HC; i++) begin
            check_value($sformatf("hc[%0d]", i), hc[i], 0);
        end

        for (int r = 0; r < NUM_ROWS; r++) run_row(r);

        repeat (G + LAT + 4) @(posedge clk);  // room for a stray done
        @(negedge clk);
        check_value("done_count", done_count, NUM_ROWS);
        check_value("checker fail_count", dut.u_checker.fail_count, 0);
        $display("test passed");
        $finish;
    end

endmodule
